//--- src.f
+incdir+hw
hw/mmu_pkg.sv
hw/mmu_csr_apb.sv
hw/mmu_tlb.sv
hw/mmu_access_check.sv
hw/mmu_top.sv
sim/tb_mmu_top.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the mmu testbench with verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f src.f --top-module tb_mmu_top -o sim_mmu

./obj_dir/sim_mmu | tee sim.log

if grep -q "Checks failed" sim.log; then
    echo "simulation reported failures, see sim.log"
    exit 1
fi

echo "simulation finished without failures"

//--- sim/tb_mmu_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "mmu_defs.svh"

module tb_mmu_top
    import mmu_pkg::*;
();

    localparam int ENTRIES    = `MMU_TLB_ENTRIES;
    localparam int NUM_REQS   = 200;
    localparam int NUM_APB    = 160;
    // three cycles per apb transfer, plus slack for reset and drains
    localparam int TIMEOUT_NS = (NUM_REQS + 3 * NUM_APB + 100) * 100;

    logic        clk;
    logic        rst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        req_valid;
    mmu_req_t    req;
    logic        resp_valid;
    mmu_resp_t   resp;
    logic        bad_offset;

    // shadow copies of the ctrl register and the tlb
    mmu_ctrl_t   ctrl_sh;
    logic        sh_valid [ENTRIES];
    vpn_t        sh_vpn   [ENTRIES];
    ppn_t        sh_ppn   [ENTRIES];
    access_tag_t sh_tag   [ENTRIES];

    mmu_resp_t   exp_q [$];
    mmu_resp_t   exp_resp;
    logic [31:0] seed;
    logic [31:0] rdata;
    logic        rerr;
    int          test_errors = 0;
    int          resp_errors = 0;
    int          lat_errors  = 0;
    int          apb_errors  = 0;
    int          errors_mark = 0;
    int          n_checked   = 0;

    mmu_top UUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .req_valid  (req_valid),
        .req        (req),
        .resp_valid (resp_valid),
        .resp       (resp)
    );

    always #50 clk = ~clk;

    assign bad_offset = !(paddr inside {`MMU_REG_CTRL, `MMU_REG_TLB_INDEX,
                                        `MMU_REG_TLB_VPN, `MMU_REG_TLB_DATA});

    // one response per request, exactly one cycle later
    assert property (@(posedge clk) disable iff (!rst_n) resp_valid == $past(req_valid))
    else begin
        $display("[ERROR] %0t: resp_valid does not follow req_valid by one cycle", $time);
        lat_errors++;
    end

    assert property (@(posedge clk) disable iff (!rst_n)
                     pslverr == (psel && penable && bad_offset))
    else begin
        $display("[ERROR] %0t: pslverr %b for offset %h", $time, pslverr, paddr);
        apb_errors++;
    end

    // the slave never inserts wait states
    assert property (@(posedge clk) disable iff (!rst_n) pready)
    else begin
        $display("[ERROR] %0t: pready low", $time);
        apb_errors++;
    end

    // resp only moves on the rising edge, so the falling edge is a quiet point
    always @(negedge clk) begin
        if (rst_n && resp_valid) begin
            if (exp_q.size() == 0) begin
                $display("a response arrived at %0t with no request outstanding", $time);
                resp_errors++;
            end else begin
                exp_resp = exp_q.pop_front();
                n_checked++;
                assert (resp == exp_resp) else begin
                    $display("[ERROR] %0t: paddr %h miss %b fault %b, expected %h %b %b",
                             $time, resp.paddr, resp.miss, resp.pagefault,
                             exp_resp.paddr, exp_resp.miss, exp_resp.pagefault);
                    resp_errors++;
                end
            end
        end
    end

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1103515245 + 32'd12345;
        return {seed[15:0], seed[31:16]};
    endfunction

    function automatic int total_errors();
        return test_errors + resp_errors + lat_errors + apb_errors;
    endfunction

    // expected response from the sv32 rules, shadow tlb and ctrl copy
    function automatic mmu_resp_t model_resp(mmu_ctrl_t c, mmu_req_t r);
        mmu_resp_t   e;
        priv_t       p;
        access_tag_t t;
        int          idx;
        logic        ok;
        e = '0;
        p = (c.cur_priv == `MMU_PRIV_MACHINE && c.mprv) ? c.mpp : c.cur_priv;
        if (p == `MMU_PRIV_MACHINE || !c.satp_mode) begin
            e.paddr = {2'b00, r.vaddr};
            return e;
        end
        idx = -1;
        for (int i = ENTRIES - 1; i >= 0; i--) begin
            if (sh_valid[i] && sh_vpn[i] == r.vaddr[31:12]) idx = i;
        end
        if (idx < 0) begin
            e.miss = 1'b1;
            return e;
        end
        t = sh_tag[idx];
        e.paddr = {sh_ppn[idx], r.vaddr[11:0]};
        ok = t[0] && (t[1] || t[3]) && t[6];
        if (p == `MMU_PRIV_USER) ok = ok && t[4];
        else if (p == `MMU_PRIV_SUPERVISOR) ok = ok && (!t[4] || c.sum);
        if (r.cmd == `MMU_CMD_STORE) ok = ok && t[7] && t[2];
        else if (r.cmd == `MMU_CMD_LOAD) ok = ok && (t[1] || (t[3] && c.mxr));
        else if (r.cmd == `MMU_CMD_EXECUTE) ok = ok && t[3];
        e.pagefault = !ok;
        return e;
    endfunction

    task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rd, output logic err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        @(negedge clk);
        rd      = prdata;
        err     = pslverr;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic set_ctrl(input mmu_ctrl_t c);
        apb_xfer(1'b1, `MMU_REG_CTRL, {24'd0, c}, rdata, rerr);
        ctrl_sh = c;
    endtask

    task automatic fill_entry(input int idx, input vpn_t v, input ppn_t p, input access_tag_t t);
        apb_xfer(1'b1, `MMU_REG_TLB_INDEX, 32'(idx), rdata, rerr);
        apb_xfer(1'b1, `MMU_REG_TLB_VPN, {12'd0, v}, rdata, rerr);
        apb_xfer(1'b1, `MMU_REG_TLB_DATA, {2'b00, p, t}, rdata, rerr);
        sh_valid[idx] = 1'b1;
        sh_vpn[idx]   = v;
        sh_ppn[idx]   = p;
        sh_tag[idx]   = t;
    endtask

    // caller has already moved to a falling edge
    task automatic issue_req(input cache_cmd_t cmd, input vaddr_t va);
        req_valid = 1'b1;
        req.cmd   = cmd;
        req.vaddr = va;
        exp_q.push_back(model_resp(ctrl_sh, req));
    endtask

    task automatic issue_rand_req();
        int   idx;
        logic [31:0] rnd;
        idx = int'(lcg_next() % ENTRIES);
        rnd = lcg_next();
        issue_req(cache_cmd_t'(1 + rnd[31:16] % 3), {sh_vpn[idx], rnd[11:0]});
    endtask

    task automatic drain();
        @(negedge clk);
        req_valid = 1'b0;
        while (exp_q.size() != 0) @(negedge clk);
    endtask

    task automatic report_test(input string name);
        $display("test %s done, %0d errors", name, total_errors() - errors_mark);
        errors_mark = total_errors();
    endtask

    task automatic perm_round(input priv_t priv, input logic mprv, input priv_t mpp, input int n);
        mmu_ctrl_t   c;
        access_tag_t t;
        logic [31:0] rnd;
        for (int i = 0; i < ENTRIES; i++) begin
            t = access_tag_t'(lcg_next());
            // bias toward V and A so the later checks are reached
            if (lcg_next() % 2 == 0) t = t | 8'h41;
            fill_entry(i, vpn_t'(20'hA0000 + i), ppn_t'(lcg_next()), t);
        end
        rnd = lcg_next();
        c = '0;
        c.satp_mode = 1'b1;
        c.cur_priv  = priv;
        c.mprv      = mprv;
        c.mpp       = mpp;
        c.mxr       = rnd[3];
        c.sum       = rnd[9];
        set_ctrl(c);
        for (int k = 0; k < n; k++) begin
            @(negedge clk);
            issue_rand_req();
        end
        drain();
    endtask

    task automatic bypass_after_reset();
        for (int k = 0; k < 20; k++) begin
            @(negedge clk);
            issue_req(cache_cmd_t'(1 + lcg_next() % 3), lcg_next());
        end
        drain();
        report_test("1 bypass after reset");
    endtask

    task automatic apb_and_fill();
        mmu_ctrl_t   c;
        logic [31:0] rnd;
        for (int i = 0; i < 4; i++) begin
            rnd = lcg_next();
            c = mmu_ctrl_t'(rnd[7:0]);
            apb_xfer(1'b1, `MMU_REG_CTRL, {24'd0, c}, rdata, rerr);
            apb_xfer(1'b0, `MMU_REG_CTRL, 32'd0, rdata, rerr);
            assert (rdata == {24'd0, c}) else begin
                $display("[ERROR] %0t: CTRL read back %h, wrote %h", $time, rdata, c);
                test_errors++;
            end
        end
        apb_xfer(1'b0, 8'h10, 32'd0, rdata, rerr);
        assert (rerr) else begin
            $display("[ERROR] %0t: no slave error on unmapped offset 10", $time);
            test_errors++;
        end
        fill_entry(0, 20'h12345, ppn_t'(lcg_next()), 8'hCF);
        apb_xfer(1'b0, `MMU_REG_TLB_VPN, 32'd0, rdata, rerr);
        assert (rdata == 32'h00012345) else begin
            $display("[ERROR] %0t: TLB_VPN read back %h", $time, rdata);
            test_errors++;
        end
        c = '0;
        c.satp_mode = 1'b1;
        c.cur_priv  = `MMU_PRIV_SUPERVISOR;
        set_ctrl(c);
        @(negedge clk);
        issue_req(`MMU_CMD_LOAD, 32'h12345ABC);
        @(negedge clk);
        issue_req(`MMU_CMD_STORE, 32'h54321010);
        drain();
        report_test("2 apb and tlb fill");
    endtask

    task automatic translate_sup_user();
        for (int r = 0; r < 6; r++) begin
            perm_round(lcg_next() % 2 == 0 ? `MMU_PRIV_USER : `MMU_PRIV_SUPERVISOR,
                       1'b0, `MMU_PRIV_USER, 12);
        end
        report_test("3 supervisor and user permissions");
    endtask

    task automatic machine_mprv();
        mmu_ctrl_t c;
        for (int r = 0; r < 4; r++) begin
            perm_round(`MMU_PRIV_MACHINE, 1'b1,
                       r % 2 == 0 ? `MMU_PRIV_USER : `MMU_PRIV_SUPERVISOR, 12);
        end
        c = '0;
        c.satp_mode = 1'b1;
        c.cur_priv  = `MMU_PRIV_MACHINE;
        set_ctrl(c);
        for (int k = 0; k < 10; k++) begin
            @(negedge clk);
            issue_rand_req();
        end
        drain();
        report_test("4 machine mode with mprv");
    endtask

    task automatic stream_overwrite();
        mmu_ctrl_t   c;
        ppn_t        new_ppn;
        access_tag_t new_tag;
        c = '0;
        c.satp_mode = 1'b1;
        c.cur_priv  = `MMU_PRIV_SUPERVISOR;
        c.sum       = 1'b1;
        set_ctrl(c);
        new_ppn = ppn_t'(lcg_next());
        new_tag = access_tag_t'(lcg_next()) | 8'h41;
        apb_xfer(1'b1, `MMU_REG_TLB_INDEX, 32'd2, rdata, rerr);
        apb_xfer(1'b1, `MMU_REG_TLB_VPN, {12'd0, sh_vpn[2]}, rdata, rerr);
        for (int k = 0; k < 24; k++) begin
            @(negedge clk);
            if (k == 10) begin
                psel    = 1'b1;
                pwrite  = 1'b1;
                paddr   = `MMU_REG_TLB_DATA;
                pwdata  = {2'b00, new_ppn, new_tag};
            end
            if (k == 11) penable = 1'b1;
            // the access cycle ended, later requests see the new entry
            if (k == 12) begin
                psel      = 1'b0;
                penable   = 1'b0;
                pwrite    = 1'b0;
                sh_ppn[2] = new_ppn;
                sh_tag[2] = new_tag;
            end
            // entry 2 on both sides of the write edge
            if (k == 11 || k == 12) begin
                issue_req(`MMU_CMD_LOAD, {sh_vpn[2], 12'h5A4});
            end else begin
                issue_rand_req();
            end
        end
        drain();
        report_test("5 back-to-back with overwrite");
    endtask

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("Checks failed");
        $finish;
    end

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        req_valid = 1'b0;
        req       = '0;
        seed      = 32'd99770;
        ctrl_sh   = '0;
        for (int i = 0; i < ENTRIES; i++) begin
            sh_valid[i] = 1'b0;
            sh_vpn[i]   = '0;
            sh_ppn[i]   = '0;
            sh_tag[i]   = '0;
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        bypass_after_reset();
        apb_and_fill();
        translate_sup_user();
        machine_mprv();
        stream_overwrite();

        @(negedge clk);
        $display("%0d responses compared, %0d errors", n_checked, total_errors());
        if (total_errors() == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hw/mmu_top.sv
`timescale 1ns/1ps
`default_nettype none

module mmu_top
    import mmu_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,

    // apb3 slave
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [7:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,

    // cache side, one request per cycle, no back-pressure
    input  logic        req_valid,
    input  mmu_req_t    req,
    output logic        resp_valid,
    output mmu_resp_t   resp
);

    mmu_ctrl_t   ctrl;
    logic        tlb_we;
    tlb_idx_t    tlb_widx;
    tlb_entry_t  tlb_wentry;
    logic        lookup_valid;
    tlb_lookup_t lookup;

    mmu_csr_apb u_csr (
        .clk        (clk),
        .rst_n      (rst_n),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .ctrl       (ctrl),
        .tlb_we     (tlb_we),
        .tlb_widx   (tlb_widx),
        .tlb_wentry (tlb_wentry)
    );

    mmu_tlb u_tlb (
        .clk          (clk),
        .rst_n        (rst_n),
        .tlb_we       (tlb_we),
        .tlb_widx     (tlb_widx),
        .tlb_wentry   (tlb_wentry),
        .req_valid    (req_valid),
        .req          (req),
        .lookup_valid (lookup_valid),
        .lookup       (lookup)
    );

    mmu_access_check u_check (
        .lookup_valid (lookup_valid),
        .lookup       (lookup),
        .ctrl         (ctrl),
        .resp_valid   (resp_valid),
        .resp         (resp)
    );

endmodule

`default_nettype wire

//--- hw/mmu_access_check.sv
`timescale 1ns/1ps
`default_nettype none

`include "mmu_defs.svh"

module mmu_access_check
    import mmu_pkg::*;
(
    input  logic        lookup_valid,
    input  tlb_lookup_t lookup,
    input  mmu_ctrl_t   ctrl,

    output logic        resp_valid,
    output mmu_resp_t   resp
);

    priv_t eff_priv;
    logic  bypass;
    logic  tag_r;
    logic  tag_w;
    logic  tag_x;
    logic  tag_u;
    logic  tag_a;
    logic  tag_d;
    logic  tag_valid;
    logic  pagefault;

    // mprv lets machine mode access memory with the mpp privilege
    assign eff_priv = ((ctrl.cur_priv == `MMU_PRIV_MACHINE) && ctrl.mprv) ?
                      ctrl.mpp : ctrl.cur_priv;

    assign bypass = (eff_priv == `MMU_PRIV_MACHINE) || !ctrl.satp_mode;

    assign tag_r = lookup.tag[`MMU_TAG_R];
    assign tag_w = lookup.tag[`MMU_TAG_W];
    assign tag_x = lookup.tag[`MMU_TAG_X];
    assign tag_u = lookup.tag[`MMU_TAG_U];
    assign tag_a = lookup.tag[`MMU_TAG_A];
    assign tag_d = lookup.tag[`MMU_TAG_D];

    // a leaf needs V plus at least one of R or X
    assign tag_valid = lookup.tag[`MMU_TAG_V] && (tag_r || tag_x);

    always_comb begin
        pagefault = 1'b0;
        if (!bypass && lookup.hit) begin
            if (!tag_valid) begin
                pagefault = 1'b1;
            end
            if (eff_priv == `MMU_PRIV_SUPERVISOR) begin
                if (tag_u && !ctrl.sum) begin
                    pagefault = 1'b1;
                end
            end else if (eff_priv == `MMU_PRIV_USER) begin
                if (!tag_u) begin
                    pagefault = 1'b1;
                end
            end
            if (!tag_a) begin
                pagefault = 1'b1;
            end else if (lookup.cmd == `MMU_CMD_STORE) begin
                if (!tag_d || !tag_w) begin
                    pagefault = 1'b1;
                end
            end else if (lookup.cmd == `MMU_CMD_LOAD) begin
                // executable pages count as readable when mxr is set
                if (!tag_r && !(ctrl.mxr && tag_x)) begin
                    pagefault = 1'b1;
                end
            end else if (lookup.cmd == `MMU_CMD_EXECUTE) begin
                if (!tag_x) begin
                    pagefault = 1'b1;
                end
            end
        end
    end

    always_comb begin
        if (bypass) begin
            resp.paddr = {2'b00, lookup.vaddr};
        end else if (lookup.hit) begin
            resp.paddr = {lookup.ppn, lookup.vaddr[11:0]};
        end else begin
            resp.paddr = '0;
        end
        resp.miss      = !bypass && !lookup.hit;
        resp.pagefault = pagefault;
    end

    assign resp_valid = lookup_valid;

endmodule

`default_nettype wire

//--- hw/mmu_tlb.sv
`timescale 1ns/1ps
`default_nettype none

`include "mmu_defs.svh"

module mmu_tlb
    import mmu_pkg::*;
#(
    parameter int ENTRIES = `MMU_TLB_ENTRIES
) (
    input  logic        clk,
    input  logic        rst_n,

    input  logic        tlb_we,
    input  tlb_idx_t    tlb_widx,
    input  tlb_entry_t  tlb_wentry,

    input  logic        req_valid,
    input  mmu_req_t    req,

    output logic        lookup_valid,
    output tlb_lookup_t lookup
);

    logic [ENTRIES-1:0] valid_q;
    vpn_t               vpn_q [ENTRIES];
    ppn_t               ppn_q [ENTRIES];
    access_tag_t        tag_q [ENTRIES];

    vpn_t               req_vpn;
    logic               hit;
    ppn_t               hit_ppn;
    access_tag_t        hit_tag;

    // reset invalidates every entry
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (tlb_we) begin
            valid_q[tlb_widx] <= tlb_wentry.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (tlb_we) begin
            vpn_q[tlb_widx] <= tlb_wentry.vpn;
            ppn_q[tlb_widx] <= tlb_wentry.ppn;
            tag_q[tlb_widx] <= tlb_wentry.tag;
        end
    end

    assign req_vpn = req.vaddr[31:12];

    // walk from the top down so the lowest matching index wins
    always_comb begin
        hit     = 1'b0;
        hit_ppn = '0;
        hit_tag = '0;
        for (int i = ENTRIES - 1; i >= 0; i--) begin
            if (valid_q[i] && (vpn_q[i] == req_vpn)) begin
                hit     = 1'b1;
                hit_ppn = ppn_q[i];
                hit_tag = tag_q[i];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lookup_valid <= 1'b0;
        end else begin
            lookup_valid <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            lookup.cmd   <= req.cmd;
            lookup.vaddr <= req.vaddr;
            lookup.hit   <= hit;
            lookup.ppn   <= hit_ppn;
            lookup.tag   <= hit_tag;
        end
    end

endmodule

`default_nettype wire

//--- hw/mmu_csr_apb.sv
`timescale 1ns/1ps
`default_nettype none

`include "mmu_defs.svh"

module mmu_csr_apb
    import mmu_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,

    input  logic       psel,
    input  logic       penable,
    input  logic       pwrite,
    input  logic [7:0] paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic       pready,
    output logic       pslverr,

    output mmu_ctrl_t  ctrl,
    output logic       tlb_we,
    output tlb_idx_t   tlb_widx,
    output tlb_entry_t tlb_wentry
);

    logic access;
    logic wr_en;
    logic addr_ok;
    vpn_t vpn_r;

    // no wait states, every transfer is setup plus one access cycle
    assign pready = 1'b1;
    assign access = psel & penable;
    assign wr_en  = access & pwrite & addr_ok;

    always_comb begin
        case (paddr)
            `MMU_REG_CTRL,
            `MMU_REG_TLB_INDEX,
            `MMU_REG_TLB_VPN,
            `MMU_REG_TLB_DATA: addr_ok = 1'b1;
            default:           addr_ok = 1'b0;
        endcase
    end

    assign pslverr = access & ~addr_ok;

    // TLB_DATA is write only and reads as zero
    always_comb begin
        case (paddr)
            `MMU_REG_CTRL:      prdata = {24'd0, ctrl};
            `MMU_REG_TLB_INDEX: prdata = 32'(tlb_widx);
            `MMU_REG_TLB_VPN:   prdata = {12'd0, vpn_r};
            default:            prdata = 32'd0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl     <= '0;
            tlb_widx <= '0;
            vpn_r    <= '0;
        end else if (wr_en) begin
            case (paddr)
                `MMU_REG_CTRL:      ctrl     <= mmu_ctrl_t'(pwdata[7:0]);
                `MMU_REG_TLB_INDEX: tlb_widx <= tlb_idx_t'(pwdata);
                `MMU_REG_TLB_VPN:   vpn_r    <= pwdata[19:0];
                default: begin
                end
            endcase
        end
    end

    // fill strobe lasts exactly the access cycle, so the TLB
    // takes the entry on the same edge that ends the transfer
    assign tlb_we = wr_en & (paddr == `MMU_REG_TLB_DATA);

    always_comb begin
        tlb_wentry.valid = 1'b1;
        tlb_wentry.vpn   = vpn_r;
        tlb_wentry.ppn   = pwdata[29:8];
        tlb_wentry.tag   = pwdata[7:0];
    end

endmodule

`default_nettype wire

//--- hw/mmu_pkg.sv
`default_nettype none

`include "mmu_defs.svh"

package mmu_pkg;

    typedef logic [1:0]  priv_t;
    typedef logic [3:0]  cache_cmd_t;
    typedef logic [31:0] vaddr_t;
    typedef logic [33:0] paddr_t;
    typedef logic [19:0] vpn_t;
    typedef logic [21:0] ppn_t;

    // V R W X U G A D, V in bit 0
    typedef logic [7:0]  access_tag_t;

    typedef logic [$clog2(`MMU_TLB_ENTRIES)-1:0] tlb_idx_t;

    // layout matches the CTRL register, satp_mode in bit 7
    typedef struct packed {
        logic  satp_mode;
        priv_t cur_priv;
        logic  mprv;
        logic  mxr;
        logic  sum;
        priv_t mpp;
    } mmu_ctrl_t;

    typedef struct packed {
        logic        valid;
        vpn_t        vpn;
        ppn_t        ppn;
        access_tag_t tag;
    } tlb_entry_t;

    typedef struct packed {
        cache_cmd_t cmd;
        vaddr_t     vaddr;
    } mmu_req_t;

    // request as seen one cycle later, with the match result
    typedef struct packed {
        cache_cmd_t  cmd;
        vaddr_t      vaddr;
        logic        hit;
        ppn_t        ppn;
        access_tag_t tag;
    } tlb_lookup_t;

    typedef struct packed {
        paddr_t paddr;
        logic   miss;
        logic   pagefault;
    } mmu_resp_t;

endpackage

`default_nettype wire

//--- hw/mmu_defs.svh
`ifndef MMU_DEFS_SVH
`define MMU_DEFS_SVH

// privilege encodings, same as mstatus.mpp
`define MMU_PRIV_USER        2'd0
`define MMU_PRIV_SUPERVISOR  2'd1
`define MMU_PRIV_MACHINE     2'd3

// cache command codes, 0 means no command
`define MMU_CMD_NONE     4'd0
`define MMU_CMD_LOAD     4'd1
`define MMU_CMD_STORE    4'd2
`define MMU_CMD_EXECUTE  4'd3

// number of fully associative entries, 2, 4 or 8
`define MMU_TLB_ENTRIES  4

// apb register offsets
`define MMU_REG_CTRL       8'h00
`define MMU_REG_TLB_INDEX  8'h04
`define MMU_REG_TLB_VPN    8'h08
`define MMU_REG_TLB_DATA   8'h0C

// sv32 pte flag positions inside the access tag
`define MMU_TAG_V  0
`define MMU_TAG_R  1
`define MMU_TAG_W  2
`define MMU_TAG_X  3
`define MMU_TAG_U  4
`define MMU_TAG_G  5
`define MMU_TAG_A  6
`define MMU_TAG_D  7

`endif
